// File: logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_idx_t;

  localparam word_t reset_pc = '0;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
    alu_xor, alu_srl, alu_sra, alu_or, alu_and
  } alu_op_t;

  typedef enum logic [3:0] {
    kind_alu, kind_lui, kind_auipc, kind_jal, kind_jalr,
    kind_branch, kind_load, kind_store, kind_illegal
  } instr_kind_t;

  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_word    = 3'b010; // lw / sw width

  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000; // sub, sra, srai

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_u;

endpackage

`default_nettype wire

// File: logic/dec_if.sv
`timescale 1ns/100ps
`default_nettype none

interface dec_if;
  rv_pkg::instr_kind_t kind;
  rv_pkg::alu_op_t     alu_op;
  logic                use_imm; // operand b from imm
  logic [2:0]          br_f3;
  rv_pkg::reg_idx_t    rd;
  rv_pkg::reg_idx_t    rs1;
  rv_pkg::reg_idx_t    rs2;
  rv_pkg::word_t       imm;

  modport dec (
    output kind, alu_op, use_imm, br_f3, rd, rs1, rs2, imm
  );

  // consumer side, execute unit and sequencer
  modport use_ (
    input kind, alu_op, use_imm, br_f3, rd, rs1, rs2, imm
  );
endinterface

`default_nettype wire

// File: logic/instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder (
  input  logic           clk,
  input  logic           rstn,
  input  rv_pkg::instr_u instr,
  dec_if.dec             dec
);
  logic [6:0]          opcode;
  logic [2:0]          f3;
  logic [6:0]          f7;
  logic                alt;
  logic                is_shift;
  rv_pkg::instr_kind_t kind_n;
  rv_pkg::alu_op_t     op_n;
  logic                use_imm_n;
  logic                use_rd;
  logic                use_rs1;
  logic                use_rs2;
  rv_pkg::word_t       imm_n;

  function automatic rv_pkg::alu_op_t alu_sel(input logic [2:0] fn, input logic alt_fn);
    case (fn)
      rv_pkg::f3_add_sub: return alt_fn ? rv_pkg::alu_sub : rv_pkg::alu_add;
      rv_pkg::f3_sll:     return rv_pkg::alu_sll;
      rv_pkg::f3_slt:     return rv_pkg::alu_slt;
      rv_pkg::f3_sltu:    return rv_pkg::alu_sltu;
      rv_pkg::f3_xor:     return rv_pkg::alu_xor;
      rv_pkg::f3_srl_sra: return alt_fn ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      rv_pkg::f3_or:      return rv_pkg::alu_or;
      default:            return rv_pkg::alu_and;
    endcase
  endfunction

  assign opcode   = instr.r.opcode;
  assign f3       = instr.r.funct3;
  assign f7       = instr.r.funct7;
  assign alt      = (f7 == rv_pkg::f7_alt);
  assign is_shift = (f3 == rv_pkg::f3_sll) || (f3 == rv_pkg::f3_srl_sra);

  always_comb begin
    kind_n    = rv_pkg::kind_illegal;
    op_n      = rv_pkg::alu_add;
    use_imm_n = 1'b0;
    use_rd    = 1'b0;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    imm_n     = '0;
    case (opcode)
      rv_pkg::opc_op: begin
        if (f7 == rv_pkg::f7_base ||
            (alt && (f3 == rv_pkg::f3_add_sub || f3 == rv_pkg::f3_srl_sra)))
          kind_n = rv_pkg::kind_alu;
        op_n    = alu_sel(f3, alt);
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      rv_pkg::opc_op_imm: begin
        if (!is_shift || f7 == rv_pkg::f7_base || (alt && f3 == rv_pkg::f3_srl_sra))
          kind_n = rv_pkg::kind_alu;
        op_n      = alu_sel(f3, alt && f3 == rv_pkg::f3_srl_sra); // addi never becomes sub
        use_imm_n = 1'b1;
        use_rd    = 1'b1;
        use_rs1   = 1'b1;
        imm_n     = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
      end
      rv_pkg::opc_lui, rv_pkg::opc_auipc: begin
        kind_n = (opcode == rv_pkg::opc_lui) ? rv_pkg::kind_lui : rv_pkg::kind_auipc;
        use_rd = 1'b1;
        imm_n  = {instr.u.imm_31_12, 12'b0};
      end
      rv_pkg::opc_jal: begin
        kind_n = rv_pkg::kind_jal;
        use_rd = 1'b1;
        imm_n  = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                  instr.j.imm_11, instr.j.imm_10_1, 1'b0};
      end
      rv_pkg::opc_jalr: begin
        kind_n  = rv_pkg::kind_jalr;
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        imm_n   = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
      end
      rv_pkg::opc_branch: begin
        if (f3 inside {rv_pkg::f3_beq, rv_pkg::f3_bne, rv_pkg::f3_blt,
                       rv_pkg::f3_bge, rv_pkg::f3_bltu, rv_pkg::f3_bgeu})
          kind_n = rv_pkg::kind_branch;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm_n   = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                   instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
      end
      rv_pkg::opc_load: begin
        if (f3 == rv_pkg::f3_word)
          kind_n = rv_pkg::kind_load;
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        imm_n   = {{20{instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
      end
      rv_pkg::opc_store: begin
        if (f3 == rv_pkg::f3_word)
          kind_n = rv_pkg::kind_store;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        imm_n   = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
      end
      default: kind_n = rv_pkg::kind_illegal;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      dec.kind    <= rv_pkg::kind_alu;
      dec.alu_op  <= rv_pkg::alu_add;
      dec.use_imm <= 1'b0;
    end else begin
      dec.kind    <= kind_n;
      dec.alu_op  <= op_n;
      dec.use_imm <= use_imm_n;
    end
  end

  always_ff @(posedge clk) begin
    dec.br_f3 <= f3;
    dec.imm   <= imm_n;
    dec.rd    <= use_rd ? instr.r.rd : '0; // unused fields read as x0
    dec.rs1   <= use_rs1 ? instr.r.rs1 : '0;
    dec.rs2   <= use_rs2 ? instr.r.rs2 : '0;
  end
endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
  input  logic             clk,
  input  logic             rstn,
  input  rv_pkg::reg_idx_t rs1_idx,
  input  rv_pkg::reg_idx_t rs2_idx,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  rv_pkg::reg_idx_t rd_idx,
  input  logic             rd_we,
  input  rv_pkg::word_t    rd_data
);
  rv_pkg::word_t regs [1:31]; // x0 has no storage

  assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
  assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd_idx != '0) begin
      regs[rd_idx] <= rd_data;
    end
  end
endmodule

`default_nettype wire

// File: logic/exec_unit.sv
`timescale 1ns/100ps
`default_nettype none

module exec_unit (
  input  logic          clk,
  input  logic          rstn,
  dec_if.use_           dec,
  input  rv_pkg::word_t rs1_data,
  input  rv_pkg::word_t rs2_data,
  input  rv_pkg::word_t pc,
  output rv_pkg::word_t result,
  output rv_pkg::word_t next_pc,
  output rv_pkg::word_t mem_addr
);
  rv_pkg::word_t op_a;
  rv_pkg::word_t rs2_v;
  rv_pkg::word_t op_b;
  rv_pkg::word_t alu_out;
  rv_pkg::word_t pc_plus4;
  rv_pkg::word_t pc_target;
  logic          taken;

  // register fields outside the format were zeroed by the decoder
  assign op_a      = (dec.rs1 == '0) ? '0 : rs1_data;
  assign rs2_v     = (dec.rs2 == '0) ? '0 : rs2_data;
  assign op_b      = dec.use_imm ? dec.imm : rs2_v;
  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + dec.imm;

  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_sub:  alu_out = op_a - op_b;
      rv_pkg::alu_sll:  alu_out = op_a << op_b[4:0];
      rv_pkg::alu_slt:  alu_out = {{(rv_pkg::xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sltu: alu_out = {{(rv_pkg::xlen-1){1'b0}}, op_a < op_b};
      rv_pkg::alu_xor:  alu_out = op_a ^ op_b;
      rv_pkg::alu_srl:  alu_out = op_a >> op_b[4:0];
      rv_pkg::alu_sra:  alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
      rv_pkg::alu_or:   alu_out = op_a | op_b;
      rv_pkg::alu_and:  alu_out = op_a & op_b;
      default:          alu_out = op_a + op_b;
    endcase
  end

  always_comb begin
    case (dec.br_f3)
      rv_pkg::f3_beq:  taken = (op_a == rs2_v);
      rv_pkg::f3_bne:  taken = (op_a != rs2_v);
      rv_pkg::f3_blt:  taken = ($signed(op_a) < $signed(rs2_v));
      rv_pkg::f3_bge:  taken = ($signed(op_a) >= $signed(rs2_v));
      rv_pkg::f3_bltu: taken = (op_a < rs2_v);
      rv_pkg::f3_bgeu: taken = (op_a >= rs2_v);
      default:         taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      result   <= '0;
      next_pc  <= '0;
      mem_addr <= '0;
    end else begin
      case (dec.kind)
        rv_pkg::kind_lui:                   result <= dec.imm;
        rv_pkg::kind_auipc:                 result <= pc_target;
        rv_pkg::kind_jal, rv_pkg::kind_jalr: result <= pc_plus4; // link value
        default:                            result <= alu_out;
      endcase
      case (dec.kind)
        rv_pkg::kind_jal:    next_pc <= pc_target;
        rv_pkg::kind_jalr:   next_pc <= (op_a + dec.imm) & ~32'd1;
        rv_pkg::kind_branch: next_pc <= taken ? pc_target : pc_plus4;
        default:             next_pc <= pc_plus4;
      endcase
      mem_addr <= op_a + dec.imm;
    end
  end
endmodule

`default_nettype wire

// File: logic/core_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module core_ctrl (
  input  logic             clk,
  input  logic             rstn,
  dec_if.use_              dec,
  input  rv_pkg::word_t    result,
  input  rv_pkg::word_t    next_pc,
  input  rv_pkg::word_t    mem_addr,
  input  rv_pkg::word_t    store_data,
  output rv_pkg::instr_u   instr,
  output rv_pkg::word_t    pc,
  output rv_pkg::reg_idx_t rd_idx,
  output logic             rd_we,
  output rv_pkg::word_t    rd_data,
  output logic             wb_cyc,
  output logic             wb_stb,
  output logic             wb_we,
  output rv_pkg::word_t    wb_adr,
  output rv_pkg::word_t    wb_wdata,
  input  rv_pkg::word_t    wb_rdata,
  input  logic             wb_ack,
  output logic             halted
);
  enum logic [2:0] {s_fetch, s_decode, s_exec, s_mem, s_write, s_halt} state;
  rv_pkg::word_t load_data;
  logic          is_mem;

  assign is_mem   = (dec.kind == rv_pkg::kind_load) || (dec.kind == rv_pkg::kind_store);
  assign wb_adr   = (state == s_mem) ? mem_addr : pc;
  assign wb_wdata = store_data;

  // write-back
  assign rd_idx  = dec.rd;
  assign rd_data = (dec.kind == rv_pkg::kind_load) ? load_data : result;
  assign rd_we   = (state == s_write) &&
                   !(dec.kind inside {rv_pkg::kind_branch, rv_pkg::kind_store,
                                      rv_pkg::kind_illegal});

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state  <= s_fetch;
      pc     <= rv_pkg::reset_pc;
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
      halted <= 1'b0;
    end else begin
      case (state)
        s_fetch: begin
          if (!wb_cyc) begin // first fetch after reset
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
          end else if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            state  <= s_decode;
          end
        end
        s_decode: state <= s_exec; // decoder registers this cycle
        s_exec: begin
          if (dec.kind == rv_pkg::kind_illegal) begin
            halted <= 1'b1;
            state  <= s_halt;
          end else if (is_mem) begin
            wb_cyc <= 1'b1; // mem_addr lands on this same edge
            wb_stb <= 1'b1;
            wb_we  <= (dec.kind == rv_pkg::kind_store);
            state  <= s_mem;
          end else begin
            state <= s_write;
          end
        end
        s_mem: begin
          if (wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
            state  <= s_write;
          end
        end
        s_write: begin
          pc     <= next_pc;
          wb_cyc <= 1'b1; // next fetch starts at once
          wb_stb <= 1'b1;
          state  <= s_fetch;
        end
        default: state <= s_halt; // parked until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_fetch && wb_cyc && wb_ack)
      instr <= wb_rdata;
    if (state == s_mem && wb_ack)
      load_data <= wb_rdata;
  end
endmodule

`default_nettype wire

// File: logic/rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module rv_core (
  input  logic          clk,
  input  logic          rstn,
  output logic          wb_cyc,
  output logic          wb_stb,
  output logic          wb_we,
  output rv_pkg::word_t wb_adr,
  output rv_pkg::word_t wb_wdata,
  input  rv_pkg::word_t wb_rdata,
  input  logic          wb_ack,
  output logic          halted
);
  rv_pkg::instr_u   instr;
  rv_pkg::word_t    pc;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    result;
  rv_pkg::word_t    next_pc;
  rv_pkg::word_t    mem_addr;
  rv_pkg::reg_idx_t rd_idx;
  logic             rd_we;
  rv_pkg::word_t    rd_data;

  dec_if dec_bus ();

  instr_decoder instr_decoder_i (
    .clk   (clk),
    .rstn  (rstn),
    .instr (instr),
    .dec   (dec_bus)
  );

  // read indices straight from the instruction register
  reg_file reg_file_i (
    .clk      (clk),
    .rstn     (rstn),
    .rs1_idx  (instr.r.rs1),
    .rs2_idx  (instr.r.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_idx   (rd_idx),
    .rd_we    (rd_we),
    .rd_data  (rd_data)
  );

  exec_unit exec_unit_i (
    .clk      (clk),
    .rstn     (rstn),
    .dec      (dec_bus),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc),
    .result   (result),
    .next_pc  (next_pc),
    .mem_addr (mem_addr)
  );

  core_ctrl core_ctrl_i (
    .clk        (clk),
    .rstn       (rstn),
    .dec        (dec_bus),
    .result     (result),
    .next_pc    (next_pc),
    .mem_addr   (mem_addr),
    .store_data (rs2_data),
    .instr      (instr),
    .pc         (pc),
    .rd_idx     (rd_idx),
    .rd_we      (rd_we),
    .rd_data    (rd_data),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_wdata   (wb_wdata),
    .wb_rdata   (wb_rdata),
    .wb_ack     (wb_ack),
    .halted     (halted)
  );
endmodule

`default_nettype wire

// File: dv/tb_tests.svh
  function automatic logic signed_less(input rv_pkg::word_t x, input rv_pkg::word_t y);
    return (x[31] != y[31]) ? x[31] : (x < y); // sign bits differ, negative wins
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input rv_pkg::word_t x,
                                        input rv_pkg::word_t y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return signed_less(x, y);
      3'b101:  return !signed_less(x, y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  function automatic rv_pkg::word_t sra_ref(input rv_pkg::word_t v, input int sh);
    rv_pkg::word_t sign_fill;
    sign_fill = v[31] ? ~(32'hffff_ffff >> sh) : '0;
    return (v >> sh) | sign_fill;
  endfunction

  task automatic alu_ops();
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t imm;
    a   = 32'hffff_fff9; // -7
    b   = 32'h0001_2345;
    imm = 32'hffff_fed4; // -300
    start_test();
    load_imm(1, a);
    load_imm(2, b);
    store_result(i_type(imm, 1, 3'b000, 3, op_imm), 0);
    store_result(r_type(7'h00, 2, 1, 3'b000, 3), 1);
    store_result(r_type(7'h20, 2, 1, 3'b000, 3), 2);
    store_result(r_type(7'h00, 2, 1, 3'b100, 3), 3);
    store_result(r_type(7'h00, 2, 1, 3'b110, 3), 4);
    store_result(r_type(7'h00, 2, 1, 3'b111, 3), 5);
    store_result(r_type(7'h00, 2, 1, 3'b010, 3), 6);
    store_result(r_type(7'h00, 1, 2, 3'b010, 3), 7);
    store_result(r_type(7'h00, 2, 1, 3'b011, 3), 8);
    store_result(r_type(7'h00, 1, 2, 3'b011, 3), 9);
    emit(halt_word);
    run_prog();
    check_word("addi", a + imm, result_at(0));
    check_word("add", a + b, result_at(1));
    check_word("sub", a - b, result_at(2));
    check_word("xor", a ^ b, result_at(3));
    check_word("or", a | b, result_at(4));
    check_word("and", a & b, result_at(5));
    check_word("slt", {31'b0, signed_less(a, b)}, result_at(6));
    check_word("slt swapped", {31'b0, signed_less(b, a)}, result_at(7));
    check_word("sltu", {31'b0, a < b}, result_at(8));
    check_word("sltu swapped", {31'b0, b < a}, result_at(9));
    finish_test("alu_ops");
  endtask

  task automatic shift_ops();
    rv_pkg::word_t v;
    rv_pkg::word_t auipc_at;
    v = 32'h8000_00f0;
    start_test();
    load_imm(1, v);
    emit(i_type(35, 0, 3'b000, 2, op_imm)); // amount 35 acts as 3
    store_result(r_type(7'h00, 2, 1, 3'b001, 3), 0);
    store_result(r_type(7'h00, 2, 1, 3'b101, 3), 1);
    store_result(r_type(7'h20, 2, 1, 3'b101, 3), 2);
    store_result(i_type(12'h007, 1, 3'b001, 3, op_imm), 3);
    store_result(i_type(12'h007, 1, 3'b101, 3, op_imm), 4);
    store_result(i_type(12'h407, 1, 3'b101, 3, op_imm), 5);
    store_result(u_type(20'habcde, 3, op_lui), 6);
    auipc_at = pc_now();
    store_result(u_type(20'h12345, 3, op_auipc), 7);
    emit(halt_word);
    run_prog();
    check_word("sll", v << 3, result_at(0));
    check_word("srl", v >> 3, result_at(1));
    check_word("sra", sra_ref(v, 3), result_at(2));
    check_word("slli", v << 7, result_at(3));
    check_word("srli", v >> 7, result_at(4));
    check_word("srai", sra_ref(v, 7), result_at(5));
    check_word("lui", 32'habcd_e000, result_at(6));
    check_word("auipc", auipc_at + 32'h1234_5000, result_at(7));
    finish_test("shift_ops");
  endtask

  task automatic load_store();
    rv_pkg::word_t val;
    val = 32'h1357_9bdf;
    start_test();
    load_imm(1, val);
    emit(s_type(12, 1, 31, 3'b010));
    emit(i_type(12, 31, 3'b010, 2, op_load));
    emit(s_type(16, 2, 31, 3'b010));
    emit(i_type(64, 31, 3'b000, 6, op_imm));
    emit(s_type(-8, 1, 6, 3'b010)); // negative offset from 0x240
    emit(i_type(-8, 6, 3'b010, 7, op_load));
    emit(s_type(20, 7, 31, 3'b010));
    emit(halt_word);
    run_prog();
    check_word("mem[0x20c]", val, mem[32'h20c >> 2]);
    check_word("mem[0x238]", val, mem[32'h238 >> 2]);
    check_word("lw x2", val, result_at(4));
    check_word("lw x7", val, result_at(5));
    check_word("wb_adr first write", 32'h200 + 12, wr_adrs[0]);
    check_word("wb_adr third write", 32'h240 - 8, wr_adrs[2]);
    finish_test("load_store");
  endtask

  task automatic branches_jumps();
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t jal_at;
    rv_pkg::word_t jalr_at;
    rv_pkg::word_t expected;
    logic [2:0]    cond [6];
    a    = 32'hffff_fffe;
    b    = 32'd5;
    cond = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    start_test();
    load_imm(1, a);
    load_imm(2, b);
    emit(i_type(12'h5ce, 0, 3'b000, 3, op_imm)); // marker
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        emit(b_type(8, (p == 0) ? 2 : 1, (p == 1) ? 2 : 1, cond[c]));
        emit(s_type(4 * (3 * c + p), 3, 31, 3'b010));
      end
    end
    jal_at = pc_now();
    emit(j_type(8, 4));
    emit(s_type(4 * 18, 3, 31, 3'b010)); // jumped over
    emit(s_type(4 * 19, 4, 31, 3'b010));
    jalr_at = pc_now() + 4;
    emit(i_type(jalr_at + 9, 0, 3'b000, 6, op_imm)); // odd target
    emit(i_type(0, 6, 3'b000, 5, op_jalr));
    emit(s_type(4 * 20, 3, 31, 3'b010)); // jumped over
    emit(s_type(4 * 21, 5, 31, 3'b010));
    emit(halt_word);
    run_prog();
    for (int c = 0; c < 6; c++) begin
      for (int p = 0; p < 3; p++) begin
        if (branch_taken(cond[c], (p == 1) ? b : a, (p == 0) ? b : a)) begin
          expected = fill_value(128 + 3 * c + p);
        end else begin
          expected = 32'h0000_05ce;
        end
        check_word($sformatf("branch f3=%b pair %0d", cond[c], p), expected,
                   result_at(3 * c + p));
      end
    end
    check_word("jal skipped store", fill_value(128 + 18), result_at(18));
    check_word("jal link", jal_at + 4, result_at(19));
    check_word("jalr skipped store", fill_value(128 + 20), result_at(20));
    check_word("jalr link", jalr_at + 4, result_at(21));
    finish_test("branches_jumps");
  endtask

  task automatic x0_writes();
    start_test();
    load_imm(1, 32'h7654_3210);
    emit(i_type(123, 0, 3'b000, 0, op_imm));
    emit(u_type(20'hfffff, 0, op_lui));
    emit(r_type(7'h00, 1, 1, 3'b000, 0));
    emit(i_type(8, 31, 3'b010, 0, op_load));
    emit(s_type(4, 0, 31, 3'b010));
    store_result(i_type(5, 0, 3'b000, 3, op_imm), 3);
    emit(halt_word);
    run_prog();
    check_word("sw x0", 32'd0, result_at(1));
    check_word("addi from x0", 32'd5, result_at(3));
    finish_test("x0_writes");
  endtask

  task automatic illegal_halt();
    start_test();
    emit(i_type(77, 0, 3'b000, 1, op_imm));
    emit(s_type(0, 1, 31, 3'b010));
    emit(halt_word);
    emit(s_type(4, 1, 31, 3'b010)); // never reached
    run_prog();
    check_flag("halted", 1'b1, halted);
    check_word("store before halt", 32'd77, result_at(0));
    repeat (20) begin
      @(negedge clk);
      check_flag("wb_cyc", 1'b0, wb_cyc);
    end
    check_flag("wb_stb", 1'b0, wb_stb);
    check_flag("wb_we", 1'b0, wb_we);
    check_flag("halted", 1'b1, halted);
    check_word("store after halt", fill_value(129), result_at(1));
    finish_test("illegal_halt");
  endtask

// File: dv/tb_rv_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;
  localparam int clk_period = 20;
  localparam int mem_words  = 256;
  localparam int ack_max    = 3;  // slave wait states, upper bound
  localparam int ack_seed   = 26;
  localparam int n_tests    = 6;
  localparam int max_prog   = 64; // longest program in words
  localparam int worst_cpi  = 4 + 2 * (ack_max + 2);
  localparam int run_limit  = max_prog * worst_cpi;
  localparam int wd_limit   = n_tests * (run_limit + 60) * clk_period;

  // rv32i major opcodes
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam rv_pkg::word_t halt_word = 32'h0000_000b; // custom-0 opcode

  logic          clk      = 1'b0;
  logic          rstn     = 1'b0;
  logic          wb_ack   = 1'b0;
  rv_pkg::word_t wb_rdata = '0;
  logic          wb_cyc;
  logic          wb_stb;
  logic          wb_we;
  rv_pkg::word_t wb_adr;
  rv_pkg::word_t wb_wdata;
  logic          halted;

  rv_pkg::word_t mem [mem_words];
  rv_pkg::word_t wr_adrs [$]; // addresses of completed writes
  int            prog_ptr;
  int            wait_left;
  logic          busy        = 1'b0;
  int            err_count   = 0;
  int            check_count = 0;
  int            test_count  = 0;
  int            test_errs;

  rv_core rv_core_i (
    .clk      (clk),
    .rstn     (rstn),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_wdata (wb_wdata),
    .wb_rdata (wb_rdata),
    .wb_ack   (wb_ack),
    .halted   (halted)
  );

  always #(clk_period / 2) clk = ~clk;

  // wishbone slave with random wait states
  initial begin
    int seed;
    seed = ack_seed;
    void'($urandom(seed));
    forever begin
      @(negedge clk);
      if (!rstn || wb_ack) begin
        wb_ack = 1'b0; // cycle closed on the last edge
        busy   = 1'b0;
      end else if (wb_cyc && wb_stb) begin
        if (!busy) begin
          busy      = 1'b1;
          wait_left = $urandom_range(ack_max, 0);
        end
        if (wait_left == 0) begin
          if (wb_we) begin
            mem[wb_adr[9:2]] = wb_wdata;
            wr_adrs.push_back(wb_adr);
          end
          wb_rdata = mem[wb_adr[9:2]];
          wb_ack   = 1'b1;
        end else begin
          wait_left--;
        end
      end
    end
  end

  task automatic check_word(input string name, input rv_pkg::word_t expected,
                            input rv_pkg::word_t actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("Error at %0t ns: %s expected %b, got %b", $time, name, expected, actual);
    end
  endtask

  function automatic rv_pkg::word_t r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
  endfunction

  function automatic rv_pkg::word_t i_type(input int imm, input int rs1, input logic [2:0] f3,
                                           input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic rv_pkg::word_t s_type(input int imm, input int rs2, input int rs1,
                                           input logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], op_store};
  endfunction

  function automatic rv_pkg::word_t b_type(input int off, input int rs2, input int rs1,
                                           input logic [2:0] f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], op_branch};
  endfunction

  function automatic rv_pkg::word_t u_type(input int imm, input int rd, input logic [6:0] opc);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic rv_pkg::word_t j_type(input int off, input int rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], op_jal};
  endfunction

  // every word differs with its address
  function automatic rv_pkg::word_t fill_value(input int idx);
    logic [7:0] a;
    a = idx[7:0];
    return {~a, a, ~a, a};
  endfunction

  function automatic rv_pkg::word_t result_at(input int slot);
    return mem[128 + slot]; // result area at 0x200
  endfunction

  function automatic rv_pkg::word_t pc_now();
    return prog_ptr * 4;
  endfunction

  task automatic emit(input rv_pkg::word_t w);
    mem[prog_ptr] = w;
    prog_ptr++;
  endtask

  task automatic load_imm(input int rd, input rv_pkg::word_t value);
    rv_pkg::word_t upper;
    upper = value + 32'h800; // addi sign-extends the low part
    emit(u_type(upper[31:12], rd, op_lui));
    emit(i_type(value[11:0], rd, 3'b000, rd, op_imm));
  endtask

  // x3 holds the value, x31 the result base
  task automatic store_result(input rv_pkg::word_t w, input int slot);
    emit(w);
    emit(s_type(4 * slot, 3, 31, 3'b010));
  endtask

  task automatic start_test();
    @(negedge clk);
    rstn = 1'b0;
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = fill_value(i);
    end
    wr_adrs.delete();
    prog_ptr  = 0;
    test_errs = err_count;
    test_count++;
    emit(i_type(12'h200, 0, 3'b000, 31, op_imm));
  endtask

  task automatic run_prog();
    int n;
    n = 0;
    repeat (4) @(negedge clk);
    rstn = 1'b1;
    while (!halted && n < run_limit) begin
      @(negedge clk);
      n++;
    end
    if (!halted) begin
      err_count++;
      $display("core did not reach its halt word within %0d cycles", run_limit);
    end
  endtask

  task automatic finish_test(input string name);
    if (err_count == test_errs) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_count - test_errs);
    end
  endtask

`include "tb_tests.svh"

  initial begin
    alu_ops();
    shift_ops();
    load_store();
    branches_jumps();
    x0_writes();
    illegal_halt();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(wd_limit);
    $display("watchdog expired after %0d ns", wd_limit);
    $display("Checks failed");
    $finish;
  end
endmodule

`default_nettype wire

// File: sources.f
+incdir+dv
logic/rv_pkg.sv
logic/dec_if.sv
logic/instr_decoder.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/core_ctrl.sv
logic/rv_core.sv
dv/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - files:
      - logic/rv_pkg.sv
      - logic/dec_if.sv
      - logic/instr_decoder.sv
      - logic/reg_file.sv
      - logic/exec_unit.sv
      - logic/core_ctrl.sv
      - logic/rv_core.sv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/tb_rv_core.sv
